/* hdl/anim_sequencer.sv */
`include "pet_display_defs.svh"

module anim_sequencer #(
    parameter int FRAME_TICK_LOG2 = 23
) (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  pet_state_pkg::pet_state_e i_pet_state,
    input  display_pkg::byte_addr_t   i_byte_addr,
    output pet_state_pkg::fetch_t     o_fetch
);

    localparam int NUM_ANIMS = 5;

    // Order: idle, sleep, eat, teach, dead.
    localparam int FRAME_CNT [NUM_ANIMS] = '{
        `PD_IDLE_FRAMES, `PD_SLEEP_FRAMES, `PD_EAT_FRAMES,
        `PD_TEACH_FRAMES, `PD_DEAD_FRAMES
    };

    // Slot bases are running sums of the frame counts.
    localparam int SLOT_BASE [NUM_ANIMS] = '{
        0,
        `PD_IDLE_FRAMES,
        `PD_IDLE_FRAMES + `PD_SLEEP_FRAMES,
        `PD_IDLE_FRAMES + `PD_SLEEP_FRAMES + `PD_EAT_FRAMES,
        `PD_IDLE_FRAMES + `PD_SLEEP_FRAMES + `PD_EAT_FRAMES + `PD_TEACH_FRAMES
    };

    logic [FRAME_TICK_LOG2-1:0] tick_cnt;
    logic                       frame_tick;
    logic [2:0]                 frame_idx [NUM_ANIMS];
    logic [2:0]                 anim_sel;
    logic                       state_valid;
    pet_state_pkg::frame_slot_t slot_next;

    assign frame_tick = &tick_cnt;  // Last cycle of a frame period.

    ////////////////////////////////////////////////////////////////////////////
    // Frame timing
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            tick_cnt <= '0;
            for (int a = 0; a < NUM_ANIMS; a++) frame_idx[a] <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
            if (frame_tick) begin
                for (int a = 0; a < NUM_ANIMS; a++) begin
                    // Each animation wraps at its own length.
                    if (frame_idx[a] == 3'(FRAME_CNT[a] - 1)) frame_idx[a] <= '0;
                    else                                     frame_idx[a] <= frame_idx[a] + 3'd1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Fetch request
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        anim_sel    = 3'd0;
        state_valid = 1'b1;
        case (i_pet_state)
            pet_state_pkg::IDLE:     anim_sel = 3'd0;
            pet_state_pkg::SLEEPING: anim_sel = 3'd1;
            pet_state_pkg::EATING:   anim_sel = 3'd2;
            pet_state_pkg::TEACHING: anim_sel = 3'd3;
            pet_state_pkg::DEAD:     anim_sel = 3'd4;
            default:                 state_valid = 1'b0;  // Multi-hot.
        endcase
        slot_next = pet_state_pkg::frame_slot_t'(SLOT_BASE[anim_sel])
                  + pet_state_pkg::frame_slot_t'(frame_idx[anim_sel]);
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_fetch <= '{slot: '0, addr: '0, blank: 1'b1};
        end else begin
            o_fetch.slot  <= state_valid ? slot_next : '0;
            o_fetch.addr  <= i_byte_addr;
            o_fetch.blank <= !state_valid;
        end
    end

    for (genvar a = 0; a < NUM_ANIMS; a++) begin : g_idx_chk
        a_idx_range: assert property (@(posedge clk) disable iff (!i_rst_n)
            frame_idx[a] < FRAME_CNT[a]);
    end

endmodule

/* hdl/display_pkg.sv */
package display_pkg;

    // Byte position inside one 1024-byte frame.
    typedef logic [9:0] byte_addr_t;

    // One byte of the frame buffer.
    typedef logic [7:0] pixel_byte_t;

    // Stat level, 0 to 100.
    typedef logic [6:0] stat_level_t;

    // The three stats shown as bars.
    typedef struct packed {
        stat_level_t happy;
        stat_level_t hunger;
        stat_level_t sleep;
    } stats_t;

    // Grade of one bar segment.
    typedef enum logic [1:0] {
        SEG_NONE  = 2'd0,  // Address is outside every bar.
        SEG_EMPTY = 2'd1,
        SEG_HALF  = 2'd2,
        SEG_FULL  = 2'd3
    } bar_seg_e;

    // One byte written into the sprite store.
    typedef struct packed {
        logic        we;
        logic [4:0]  slot;
        byte_addr_t  addr;
        pixel_byte_t data;
    } sprite_wr_t;

endpackage

/* hdl/pet_display_top.sv */
module pet_display_top #(
    parameter int FRAME_TICK_LOG2 = 23
) (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  pet_state_pkg::pet_state_e i_pet_state,
    input  display_pkg::byte_addr_t   i_byte_addr,
    input  display_pkg::stats_t       i_stats,
    input  display_pkg::sprite_wr_t   i_sprite_wr,
    output display_pkg::pixel_byte_t  o_pixel_byte
);

    pet_state_pkg::fetch_t fetch;  // Stage 1 to stage 2.
    display_pkg::bar_seg_e seg;

    // Stage 1, sprite side.
    anim_sequencer #(
        .FRAME_TICK_LOG2 (FRAME_TICK_LOG2)
    ) anim_sequencer_i (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_pet_state (i_pet_state),
        .i_byte_addr (i_byte_addr),
        .o_fetch     (fetch)
    );

    // Stage 1, bar side.
    status_bar_mapper status_bar_mapper_i (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_byte_addr (i_byte_addr),
        .i_stats     (i_stats),
        .o_seg       (seg)
    );

    // Stage 2.
    sprite_store sprite_store_i (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_sprite_wr  (i_sprite_wr),
        .i_fetch      (fetch),
        .i_seg        (seg),
        .o_pixel_byte (o_pixel_byte)
    );

endmodule

/* hdl/pet_state_pkg.sv */
package pet_state_pkg;

    // Pet states; idle is all zeros, the rest one-hot.
    typedef enum logic [3:0] {
        IDLE     = 4'b0000,
        SLEEPING = 4'b0001,
        EATING   = 4'b0010,
        TEACHING = 4'b0100,
        DEAD     = 4'b1000
    } pet_state_e;

    // Index of a frame in the sprite store.
    typedef logic [4:0] frame_slot_t;

    // Request to the sprite store, one per address.
    typedef struct packed {
        frame_slot_t             slot;
        display_pkg::byte_addr_t addr;
        logic                    blank;  // Unknown state, send zero.
    } fetch_t;

endpackage

/* hdl/sprite_store.sv */
`include "pet_display_defs.svh"

module sprite_store (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  display_pkg::sprite_wr_t   i_sprite_wr,
    input  pet_state_pkg::fetch_t     i_fetch,
    input  display_pkg::bar_seg_e     i_seg,
    output display_pkg::pixel_byte_t  o_pixel_byte
);

    localparam int MEM_W = $bits(pet_state_pkg::frame_slot_t) + $bits(display_pkg::byte_addr_t);

    display_pkg::pixel_byte_t mem [0:`PD_SPRITE_SLOTS*`PD_FRAME_BYTES-1];
    logic [MEM_W-1:0]         wr_idx;
    logic [MEM_W-1:0]         rd_idx;
    display_pkg::pixel_byte_t seg_byte;

    // Frame of 1024 bytes, so slot and address just concatenate.
    assign wr_idx = {i_sprite_wr.slot, i_sprite_wr.addr};
    assign rd_idx = {i_fetch.slot, i_fetch.addr};

    always_ff @(posedge clk) begin
        if (i_sprite_wr.we) mem[wr_idx] <= i_sprite_wr.data;
    end

    always_comb begin
        case (i_seg)
            display_pkg::SEG_FULL: seg_byte = `PD_SEG_FULL;
            display_pkg::SEG_HALF: seg_byte = `PD_SEG_HALF;
            default:               seg_byte = '0;  // Empty segment.
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read and merge, bar over sprite
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!i_rst_n)                          o_pixel_byte <= '0;
        else if (i_seg != display_pkg::SEG_NONE) o_pixel_byte <= seg_byte;
        else if (i_fetch.blank)                o_pixel_byte <= '0;
        else                                   o_pixel_byte <= mem[rd_idx];
    end

    a_wr_slot: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_sprite_wr.we |-> (i_sprite_wr.slot < `PD_SPRITE_SLOTS));

endmodule

/* hdl/status_bar_mapper.sv */
`include "pet_display_defs.svh"

module status_bar_mapper (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  display_pkg::byte_addr_t i_byte_addr,
    input  display_pkg::stats_t     i_stats,
    output display_pkg::bar_seg_e   o_seg
);

    logic [6:0]            row;
    logic [2:0]            col;
    logic                  col_ok;
    display_pkg::bar_seg_e seg_next;

    // True when the row falls inside the bar that starts at row0.
    function automatic logic in_bar(input logic [6:0] r, input int row0);
        return (int'(r) >= row0) && (int'(r) < row0 + `PD_BAR_ROWS);
    endfunction

    // Grades one segment column against its stat.
    function automatic display_pkg::bar_seg_e grade(input display_pkg::stat_level_t stat,
                                                    input logic [2:0] c);
        int full_thr;
        int half_thr;
        full_thr = `PD_SEG_FULL_BASE - `PD_SEG_STEP * int'(c);
        half_thr = `PD_SEG_HALF_BASE - `PD_SEG_STEP * int'(c);
        if (int'(stat) > full_thr)      return display_pkg::SEG_FULL;
        else if (int'(stat) > half_thr) return display_pkg::SEG_HALF;
        else                            return display_pkg::SEG_EMPTY;
    endfunction

    assign row    = 7'(i_byte_addr / `PD_ROW_BYTES);
    assign col    = 3'(i_byte_addr % `PD_ROW_BYTES);
    assign col_ok = (col >= 3'd1) && (col <= 3'd5);  // Segment columns.

    always_comb begin
        seg_next = display_pkg::SEG_NONE;
        if (col_ok) begin
            if (in_bar(row, `PD_HAPPY_ROW0))       seg_next = grade(i_stats.happy, col);
            else if (in_bar(row, `PD_HUNGER_ROW0)) seg_next = grade(i_stats.hunger, col);
            else if (in_bar(row, `PD_SLEEP_ROW0))  seg_next = grade(i_stats.sleep, col);
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) o_seg <= display_pkg::SEG_NONE;
        else          o_seg <= seg_next;
    end

    // A graded segment must come from a segment column one cycle back.
    a_seg_col: assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_seg != display_pkg::SEG_NONE) |-> ($past(i_byte_addr[2:0]) inside {[3'd1:3'd5]}));

endmodule

/* include/pet_display_defs.svh */
`ifndef PET_DISPLAY_DEFS_SVH
`define PET_DISPLAY_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Sprite store geometry
////////////////////////////////////////////////////////////////////////////

`define PD_SPRITE_SLOTS  30    // Frame slots in the store.
`define PD_FRAME_BYTES   1024  // Bytes in one frame.
`define PD_ROW_BYTES     8     // Bytes in one display row.

// Frames per animation, in store order.
`define PD_IDLE_FRAMES   6
`define PD_SLEEP_FRAMES  4
`define PD_EAT_FRAMES    5
`define PD_TEACH_FRAMES  7
`define PD_DEAD_FRAMES   8

////////////////////////////////////////////////////////////////////////////
// Status bars
////////////////////////////////////////////////////////////////////////////

`define PD_HAPPY_ROW0    8     // First row of each bar.
`define PD_HUNGER_ROW0   18
`define PD_SLEEP_ROW0    28
`define PD_BAR_ROWS      5

// Column k is full above FULL_BASE - STEP*k, half above HALF_BASE - STEP*k.
`define PD_SEG_FULL_BASE 110
`define PD_SEG_HALF_BASE 100
`define PD_SEG_STEP      20

`define PD_SEG_FULL      8'hEE // Two lit blocks.
`define PD_SEG_HALF      8'hE0 // One lit block.

`endif

/* pet_display.f */
+incdir+include
hdl/display_pkg.sv
hdl/pet_state_pkg.sv
hdl/anim_sequencer.sv
hdl/status_bar_mapper.sv
hdl/sprite_store.sv
hdl/pet_display_top.sv
sim/clock_gen.sv
sim/pet_display_checker.sv
sim/tb_pet_display.sv

/* sim/clock_gen.sv */
module clock_gen #(
    parameter int PERIOD_NS  = 4,
    parameter int RST_CYCLES = 4
) (
    output logic o_clk,
    output logic o_rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
    end

    // Release on a falling edge, away from the sampling edge.
    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule

/* sim/pet_display_checker.sv */
`include "pet_display_defs.svh"

module pet_display_checker #(
    parameter int FRAME_TICK_LOG2 = 23
) (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  pet_state_pkg::pet_state_e i_pet_state,
    input  display_pkg::byte_addr_t   i_byte_addr,
    input  display_pkg::stats_t       i_stats,
    input  display_pkg::sprite_wr_t   i_sprite_wr,
    input  logic                      i_check,      // Compare this request.
    input  logic                      i_exp_given,  // Expected byte comes from the trace.
    input  display_pkg::pixel_byte_t  i_exp_byte,
    input  display_pkg::pixel_byte_t  i_pixel_byte,
    output int                        o_errors,
    output int                        o_checks
);
    timeunit 1ns;
    timeprecision 100ps;

    // One request on its way through the two DUT stages.
    typedef struct packed {
        logic       valid;
        logic       known;
        logic [7:0] exp;
        logic [9:0] addr;
        logic [3:0] state;
    } pend_t;

    display_pkg::pixel_byte_t model_mem [int];  // Bytes written so far by flat index.
    pend_t stage1 = '0;
    pend_t stage2 = '0;
    int    cycle  = 0;  // Rising edges since reset release.
    int    errors = 0;
    int    checks = 0;

    assign o_errors = errors;
    assign o_checks = checks;

    // Byte for one bar column from the column thresholds.
    function automatic logic [7:0] bar_byte(input int stat, input int col);
        if (stat > `PD_SEG_FULL_BASE - `PD_SEG_STEP * col)      return `PD_SEG_FULL;
        else if (stat > `PD_SEG_HALF_BASE - `PD_SEG_STEP * col) return `PD_SEG_HALF;
        else                                                    return 8'h00;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic predict(input logic [3:0] st, input logic [9:0] addr,
                           input display_pkg::stats_t s, input int k,
                           output logic known, output logic [7:0] b);
        int row;
        int col;
        int base;
        int cnt;
        int key;
        known = 1'b1;
        b     = 8'h00;
        row   = int'(addr) / `PD_ROW_BYTES;
        col   = int'(addr) % `PD_ROW_BYTES;
        if (col >= 1 && col <= 5) begin
            if (row >= `PD_HAPPY_ROW0 && row < `PD_HAPPY_ROW0 + `PD_BAR_ROWS) begin
                b = bar_byte(int'(s.happy), col);
                return;
            end
            if (row >= `PD_HUNGER_ROW0 && row < `PD_HUNGER_ROW0 + `PD_BAR_ROWS) begin
                b = bar_byte(int'(s.hunger), col);
                return;
            end
            if (row >= `PD_SLEEP_ROW0 && row < `PD_SLEEP_ROW0 + `PD_BAR_ROWS) begin
                b = bar_byte(int'(s.sleep), col);
                return;
            end
        end
        case (st)
            4'b0000: begin
                base = 0;
                cnt  = `PD_IDLE_FRAMES;
            end
            4'b0001: begin
                base = 6;
                cnt  = `PD_SLEEP_FRAMES;
            end
            4'b0010: begin
                base = 10;
                cnt  = `PD_EAT_FRAMES;
            end
            4'b0100: begin
                base = 15;
                cnt  = `PD_TEACH_FRAMES;
            end
            4'b1000: begin
                base = 22;
                cnt  = `PD_DEAD_FRAMES;
            end
            default: return;  // Unknown state blanks.
        endcase
        key = (base + (k >> FRAME_TICK_LOG2) % cnt) * `PD_FRAME_BYTES + int'(addr);
        if (model_mem.exists(key)) b = model_mem[key];
        else                       known = 1'b0;
    endtask

    always @(posedge clk) begin : track
        pend_t      req;
        logic       known;
        logic [7:0] b;
        if (!i_rst_n) begin
            stage1 = '0;
            stage2 = '0;
            cycle  = 0;
        end else begin
            if (i_sprite_wr.we)
                model_mem[int'(i_sprite_wr.slot) * `PD_FRAME_BYTES + int'(i_sprite_wr.addr)] =
                    i_sprite_wr.data;
            predict(i_pet_state, i_byte_addr, i_stats, cycle, known, b);
            req.valid = i_check;
            req.known = i_exp_given || known;
            req.exp   = i_exp_given ? i_exp_byte : b;
            req.addr  = i_byte_addr;
            req.state = i_pet_state;
            stage2    = stage1;
            stage1    = req;
            cycle++;
        end
    end

    // Output is stable around the falling edge.
    always @(negedge clk) begin
        if (stage2.valid) begin
            checks++;
            if (!stage2.known) begin
                $display("Check at %0t ns has no expected byte, address %03h never written",
                         $time, stage2.addr);
                errors++;
            end else if (i_pixel_byte !== stage2.exp) begin
                $display("FAILED at %0t ns: addr %03h state %b expected %02h got %02h",
                         $time, stage2.addr, stage2.state, stage2.exp, i_pixel_byte);
                errors++;
            end
        end
    end

endmodule

/* sim/pet_display_trace.txt */
# W slot(hex) addr(hex) data(hex) count : fills count slots from slot, data counting up
# R state(hex) addr(hex) happy hunger sleep expected(hex, -- from model) repeat
W 00 002 40 30
W 00 039 80 30
W 00 06a a0 30
W 00 040 c0 30
W 00 046 10 30
# Sprite lookup in every state, then a new address every cycle
R 0 002 0 0 0 -- 1
R 1 002 0 0 0 -- 1
R 2 002 0 0 0 -- 1
R 4 002 0 0 0 -- 1
R 8 002 0 0 0 -- 1
R 1 039 0 0 0 -- 1
R 1 06a 0 0 0 -- 1
R 2 040 0 0 0 -- 1
R 4 046 0 0 0 -- 1
R 8 039 0 0 0 -- 1
# Frame advance, dead then idle held
R 8 002 0 0 0 -- 140
R 0 002 0 0 0 -- 100
# Status bars
R 1 041 55 0 0 00 1
R 1 042 55 0 0 00 1
R 1 043 55 0 0 ee 1
R 1 044 55 0 0 ee 1
R 1 045 55 0 0 ee 1
R 1 091 0 85 0 e0 1
R 1 092 0 85 0 ee 1
R 1 0e4 0 0 15 00 1
R 1 0e5 0 0 15 ee 1
R 1 101 0 0 100 ee 1
R 1 065 0 0 0 00 1
# Bar bounds show the sprite
R 2 040 100 100 100 -- 1
R 2 046 100 100 100 -- 1
R 2 039 100 100 100 -- 1
R 2 06a 100 100 100 -- 1
# Blanking on multi-hot states
R 3 002 0 0 0 00 1
R c 043 100 0 0 ee 1
R 3 039 100 0 0 -- 1

/* sim/tb_pet_display.sv */
module tb_pet_display;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TICK_LOG2 = 4;
    localparam int CYCLE_NS  = 4;

    // One expanded trace operation.
    typedef struct packed {
        logic       is_wr;
        logic [4:0] slot;
        logic [9:0] addr;
        logic [7:0] data;
        logic [3:0] state;
        logic [6:0] happy;
        logic [6:0] hunger;
        logic [6:0] sleep;
        logic       exp_given;
        logic [7:0] exp;
    } op_t;

    logic                      clk;
    logic                      rst_n;
    pet_state_pkg::pet_state_e pet_state;
    display_pkg::byte_addr_t   byte_addr;
    display_pkg::stats_t       stats;
    display_pkg::sprite_wr_t   sprite_wr;
    display_pkg::pixel_byte_t  pixel_byte;
    logic                      check_en;
    logic                      exp_given;
    display_pkg::pixel_byte_t  exp_byte;
    int                        errors;
    int                        checks;
    int                        parse_errors = 0;
    logic                      ops_loaded   = 1'b0;
    op_t                       ops [$];

    clock_gen #(.PERIOD_NS(CYCLE_NS), .RST_CYCLES(4)) clock_gen_i (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    pet_display_top #(.FRAME_TICK_LOG2(TICK_LOG2)) dut_i (
        .clk          (clk),
        .i_rst_n      (rst_n),
        .i_pet_state  (pet_state),
        .i_byte_addr  (byte_addr),
        .i_stats      (stats),
        .i_sprite_wr  (sprite_wr),
        .o_pixel_byte (pixel_byte)
    );

    pet_display_checker #(.FRAME_TICK_LOG2(TICK_LOG2)) checker_i (
        .clk          (clk),
        .i_rst_n      (rst_n),
        .i_pet_state  (pet_state),
        .i_byte_addr  (byte_addr),
        .i_stats      (stats),
        .i_sprite_wr  (sprite_wr),
        .i_check      (check_en),
        .i_exp_given  (exp_given),
        .i_exp_byte   (exp_byte),
        .i_pixel_byte (pixel_byte),
        .o_errors     (errors),
        .o_checks     (checks)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Trace reading
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_trace(output logic ok);
        int    fd;
        int    n;
        int    cnt;
        int    slot;
        int    addr;
        int    data;
        int    st;
        int    h;
        int    u;
        int    s;
        string line;
        string exp_str;
        op_t   op;
        ok = 1'b0;
        fd = $fopen("sim/pet_display_trace.txt", "r");
        if (fd == 0) return;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;
            op = '0;
            if (line[0] == "W") begin
                n = $sscanf(line, "W %h %h %h %d", slot, addr, data, cnt);
                if (n != 4) begin
                    $display("Unreadable write line in trace: %s", line);
                    parse_errors++;
                    continue;
                end
                for (int i = 0; i < cnt; i++) begin  // Consecutive slots, data counts up.
                    op.is_wr = 1'b1;
                    op.slot  = 5'(slot + i);
                    op.addr  = 10'(addr);
                    op.data  = 8'(data + i);
                    ops.push_back(op);
                end
            end else begin
                n = $sscanf(line, "R %h %h %d %d %d %s %d", st, addr, h, u, s, exp_str, cnt);
                if (n != 7) begin
                    $display("Unreadable read line in trace: %s", line);
                    parse_errors++;
                    continue;
                end
                op.state     = 4'(st);
                op.addr      = 10'(addr);
                op.happy     = 7'(h);
                op.hunger    = 7'(u);
                op.sleep     = 7'(s);
                op.exp_given = (exp_str != "--");
                op.exp       = op.exp_given ? 8'(exp_str.atohex()) : 8'h00;
                repeat (cnt) ops.push_back(op);
            end
        end
        $fclose(fd);
        ok = 1'b1;
    endtask

    initial begin : run
        logic ok;
        pet_state = pet_state_pkg::IDLE;
        byte_addr = '0;
        stats     = '0;
        sprite_wr = '0;
        check_en  = 1'b0;
        exp_given = 1'b0;
        exp_byte  = '0;
        load_trace(ok);
        if (!ok) begin
            $display("Could not open the trace file sim/pet_display_trace.txt");
            $display("Done: errors found");
            $finish;
        end else begin
            ops_loaded = 1'b1;
            wait (rst_n === 1'b1);
            foreach (ops[i]) begin
                @(negedge clk);
                sprite_wr.we   = ops[i].is_wr;
                sprite_wr.slot = ops[i].slot;
                sprite_wr.addr = ops[i].addr;
                sprite_wr.data = ops[i].data;
                pet_state      = pet_state_pkg::pet_state_e'(ops[i].state);
                byte_addr      = ops[i].addr;
                stats          = '{happy: ops[i].happy, hunger: ops[i].hunger,
                                   sleep: ops[i].sleep};
                check_en       = !ops[i].is_wr;
                exp_given      = ops[i].exp_given;
                exp_byte       = ops[i].exp;
            end
            @(negedge clk);
            check_en     = 1'b0;
            sprite_wr.we = 1'b0;
            repeat (4) @(negedge clk);  // Drain the pipeline.
            $display("Checks: %0d, errors: %0d, trace errors: %0d",
                     checks, errors, parse_errors);
            if (errors == 0 && parse_errors == 0 && checks > 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
            $finish;
        end
    end

    // Watchdog, sized from the trace length.
    initial begin : watchdog
        int limit;
        wait (ops_loaded);
        limit = ops.size() * 20 + 200;
        #(limit * CYCLE_NS);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Done: errors found");
        $finish;
    end

endmodule
